// ==== rtl/vend_macros.svh ====
`ifndef VEND_MACROS_SVH
`define VEND_MACROS_SVH

// product positions
`define VEND_SLOTS          4

// button vector layout
`define VEND_BTN_W          12
`define VEND_BTN_UP         10
`define VEND_BTN_DOWN       4
`define VEND_BTN_SELECT     7
`define VEND_BTN_BUY        9
`define VEND_BTN_RETURN     3
`define VEND_BTN_RESTOCK    5
`define VEND_BTN_COIN_LO    0

// coin values, small sits on the highest coin bit
`define VEND_COIN_SMALL     1
`define VEND_COIN_MID       5
`define VEND_COIN_LARGE     10

`define VEND_STOCK_LIMIT    9

`define VEND_INIT_STOCK_0   9
`define VEND_INIT_STOCK_1   1
`define VEND_INIT_STOCK_2   0
`define VEND_INIT_STOCK_3   4

`define VEND_PRICE_0        10
`define VEND_PRICE_1        12
`define VEND_PRICE_2        15
`define VEND_PRICE_3        18

`endif

// ==== rtl/vend_pkg.sv ====
package vend_pkg;

    typedef logic [7:0] credit_t;
    typedef logic [3:0] stock_t;
    typedef logic [1:0] slot_idx_t;
    // 0 is no item, otherwise position plus one
    typedef logic [2:0] item_t;

    typedef enum logic [2:0] {
        op_none    = 3'd0,
        op_move    = 3'd1,
        op_select  = 3'd2,
        op_coin    = 3'd3,
        op_buy     = 3'd4,
        op_return  = 3'd5,
        op_restock = 3'd6,
        op_admin   = 3'd7
    } op_e;

    typedef enum logic [1:0] {
        st_none         = 2'd0,
        st_short_credit = 2'd1,
        st_sold         = 2'd2,
        st_admin        = 2'd3
    } status_e;

    // one command word per cycle from the panel
    typedef struct packed {
        op_e       op;
        credit_t   coin;
        slot_idx_t slot;
    } panel_cmd_t;

    typedef struct packed {
        stock_t  stock;
        logic    sold;
        logic    short;
        credit_t charge;
    } slot_report_t;

endpackage

// ==== rtl/panel_decoder.sv ====
`timescale 1ns/1ns
`include "vend_macros.svh"

module panel_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`VEND_BTN_W-1:0] button_sw_oneshot,
    input  logic                  admin_mode,
    input  logic                  admin_oneshot,
    input  vend_pkg::stock_t      stock [`VEND_SLOTS],
    output vend_pkg::panel_cmd_t  cmd,
    output vend_pkg::slot_idx_t   cursor,
    output vend_pkg::item_t       selected_item,
    output vend_pkg::stock_t      shown_stock
);
    import vend_pkg::*;

    logic       move_up;
    logic       move_down;
    logic       select_sw;
    logic       buy_sw;
    logic       return_sw;
    logic       restock_sw;
    logic [2:0] coin_sw;
    item_t      cursor_item;
    slot_idx_t  sel_slot;

    assign move_up     = button_sw_oneshot[`VEND_BTN_UP];
    assign move_down   = button_sw_oneshot[`VEND_BTN_DOWN];
    assign select_sw   = button_sw_oneshot[`VEND_BTN_SELECT];
    assign buy_sw      = button_sw_oneshot[`VEND_BTN_BUY];
    assign return_sw   = button_sw_oneshot[`VEND_BTN_RETURN];
    assign restock_sw  = button_sw_oneshot[`VEND_BTN_RESTOCK];
    assign coin_sw     = button_sw_oneshot[`VEND_BTN_COIN_LO +: 3];

    assign cursor_item = item_t'(cursor) + 3'd1;
    assign sel_slot    = slot_idx_t'(selected_item - 3'd1);
    assign shown_stock = stock[cursor];

    ////////////////////////////////////////////////////////////////////////////
    // command priority
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        cmd.op   = op_none;
        cmd.coin = '0;
        cmd.slot = cursor;
        if (move_up || move_down) begin
            cmd.op = op_move;
        end else if (select_sw) begin
            cmd.op = op_select;
        end else if (coin_sw != 3'b000) begin
            cmd.op = op_coin;
            if (coin_sw[2]) begin
                cmd.coin = credit_t'(`VEND_COIN_SMALL);
            end else if (coin_sw[1]) begin
                cmd.coin = credit_t'(`VEND_COIN_MID);
            end else begin
                cmd.coin = credit_t'(`VEND_COIN_LARGE);
            end
        end else if (buy_sw) begin
            // buy with nothing selected is swallowed
            if (selected_item != '0) begin
                cmd.op   = op_buy;
                cmd.slot = sel_slot;
            end
        end else if (return_sw) begin
            cmd.op = op_return;
        end else if (restock_sw) begin
            if (admin_mode) begin
                cmd.op = op_restock;
            end
        end else if (admin_oneshot) begin
            cmd.op = op_admin;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // cursor and selection
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            cursor        <= '0;
            selected_item <= '0;
        end else begin
            case (cmd.op)
                op_move: begin
                    // up wins when both are pressed
                    if (move_up) begin
                        if (cursor != '0)
                            cursor <= cursor - 2'd1;
                    end else if (cursor != slot_idx_t'(`VEND_SLOTS - 1)) begin
                        cursor <= cursor + 2'd1;
                    end
                end
                op_select: begin
                    if (selected_item == cursor_item)
                        selected_item <= '0;
                    else if (shown_stock != '0)
                        selected_item <= cursor_item;
                end
                op_buy:  selected_item <= '0;
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/product_slot.sv ====
`timescale 1ns/1ns
`include "vend_macros.svh"

module product_slot #(
    parameter int                  INIT_STOCK = 0,
    parameter int                  PRICE      = 10,
    parameter vend_pkg::slot_idx_t SLOT_ID    = '0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  vend_pkg::panel_cmd_t   cmd,
    input  vend_pkg::credit_t      credit,
    output vend_pkg::slot_report_t report
);
    import vend_pkg::*;

    stock_t stock;
    logic   hit;
    logic   buy_hit;
    logic   can_sell;
    logic   restock_ok;

    assign hit        = (cmd.slot == SLOT_ID);
    assign buy_hit    = hit && (cmd.op == op_buy);
    // exact payment is enough
    assign can_sell   = (stock != '0) && (credit >= credit_t'(PRICE));
    assign restock_ok = hit && (cmd.op == op_restock)
                        && (stock < stock_t'(`VEND_STOCK_LIMIT));

    // report straight from the command, ledger acts on the same edge
    always_comb begin
        report.stock  = stock;
        report.sold   = buy_hit && can_sell;
        report.short  = buy_hit && !can_sell;
        report.charge = (buy_hit && can_sell) ? credit_t'(PRICE) : '0;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            stock <= stock_t'(INIT_STOCK);
        end else if (buy_hit && can_sell) begin
            stock <= stock - 4'd1;
        end else if (restock_ok) begin
            stock <= stock + 4'd1;
        end
    end

endmodule

// ==== rtl/sale_ledger.sv ====
`timescale 1ns/1ns
`include "vend_macros.svh"

module sale_ledger (
    input  logic                   clk,
    input  logic                   rst,
    input  vend_pkg::panel_cmd_t   cmd,
    input  vend_pkg::slot_report_t report [`VEND_SLOTS],
    output vend_pkg::credit_t      credit,
    output vend_pkg::status_e      status,
    output vend_pkg::credit_t      refund,
    output logic                   refund_valid
);
    import vend_pkg::*;

    logic       any_sold;
    logic       any_short;
    credit_t    charge;
    logic [8:0] coin_sum;

    ////////////////////////////////////////////////////////////////////////////
    // slot report merge
    ////////////////////////////////////////////////////////////////////////////
    // only the addressed slot answers, so OR is enough
    always_comb begin
        any_sold  = 1'b0;
        any_short = 1'b0;
        charge    = '0;
        for (int i = 0; i < `VEND_SLOTS; i++) begin
            any_sold  = any_sold | report[i].sold;
            any_short = any_short | report[i].short;
            charge    = charge | report[i].charge;
        end
    end

    assign coin_sum = {1'b0, credit} + {1'b0, cmd.coin};

    ////////////////////////////////////////////////////////////////////////////
    // credit, status and refund
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            credit       <= '0;
            status       <= st_none;
            refund       <= '0;
            refund_valid <= 1'b0;
        end else begin
            refund_valid <= 1'b0;
            case (cmd.op)
                op_coin: begin
                    // saturate at full scale
                    credit <= coin_sum[8] ? 8'hff : coin_sum[7:0];
                    status <= st_none;
                end
                op_buy: begin
                    if (any_sold) begin
                        credit <= credit - charge;
                        status <= st_sold;
                    end else if (any_short) begin
                        status <= st_short_credit;
                    end
                end
                op_return: begin
                    refund       <= credit;
                    // a return right after a return gives no second pulse
                    refund_valid <= !refund_valid;
                    credit       <= '0;
                    status       <= st_none;
                end
                op_admin: status <= st_admin;
                op_move, op_select, op_restock: status <= st_none;
                // idle cycle keeps everything
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/vending_core.sv ====
`timescale 1ns/1ns
`include "vend_macros.svh"

module vending_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`VEND_BTN_W-1:0] button_sw_oneshot,
    input  logic                   admin_mode,
    input  logic                   admin_oneshot,
    output vend_pkg::credit_t      credit,
    output vend_pkg::slot_idx_t    cursor,
    output vend_pkg::item_t        selected_item,
    output vend_pkg::stock_t       shown_stock,
    output vend_pkg::status_e      status,
    output vend_pkg::credit_t      refund,
    output logic                   refund_valid
);
    import vend_pkg::*;

    localparam int INIT_STOCK [`VEND_SLOTS] = '{
        `VEND_INIT_STOCK_0, `VEND_INIT_STOCK_1, `VEND_INIT_STOCK_2, `VEND_INIT_STOCK_3
    };
    localparam int PRICE [`VEND_SLOTS] = '{
        `VEND_PRICE_0, `VEND_PRICE_1, `VEND_PRICE_2, `VEND_PRICE_3
    };

    panel_cmd_t   cmd;
    stock_t       stock [`VEND_SLOTS];
    slot_report_t report [`VEND_SLOTS];

    panel_decoder i_decoder (
        .clk               (clk),
        .rst               (rst),
        .button_sw_oneshot (button_sw_oneshot),
        .admin_mode        (admin_mode),
        .admin_oneshot     (admin_oneshot),
        .stock             (stock),
        .cmd               (cmd),
        .cursor            (cursor),
        .selected_item     (selected_item),
        .shown_stock       (shown_stock)
    );

    ////////////////////////////////////////////////////////////////////////////
    // one slot per product
    ////////////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < `VEND_SLOTS; i++) begin : g_slot
        product_slot #(
            .INIT_STOCK (INIT_STOCK[i]),
            .PRICE      (PRICE[i]),
            .SLOT_ID    (slot_idx_t'(i))
        ) i_slot (
            .clk    (clk),
            .rst    (rst),
            .cmd    (cmd),
            .credit (credit),
            .report (report[i])
        );

        // stock back to the panel
        assign stock[i] = report[i].stock;
    end

    sale_ledger i_ledger (
        .clk          (clk),
        .rst          (rst),
        .cmd          (cmd),
        .report       (report),
        .credit       (credit),
        .status       (status),
        .refund       (refund),
        .refund_valid (refund_valid)
    );

endmodule

// ==== verification/vend_clock.sv ====
`timescale 1ns/1ns

module vend_clock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // active low, released just after a rising edge
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b1;
    end

endmodule

// ==== verification/vend_properties.sv ====
`timescale 1ns/1ns
`include "vend_macros.svh"

module vend_properties (
    input logic                   clk,
    input logic                   rst,
    input logic                   refund_valid,
    input vend_pkg::item_t        selected_item,
    input vend_pkg::slot_report_t report [`VEND_SLOTS]
);
    import vend_pkg::*;

    int   fail_count = 0;
    logic over_limit;
    int   sold_count;

    always_comb begin
        over_limit = 1'b0;
        sold_count = 0;
        for (int i = 0; i < `VEND_SLOTS; i++) begin
            over_limit = over_limit | (report[i].stock > stock_t'(`VEND_STOCK_LIMIT));
            sold_count = sold_count + int'(report[i].sold);
        end
    end

    a_refund_pulse: assert property (@(posedge clk) disable iff (!rst)
        refund_valid |=> !refund_valid)
        else begin
            fail_count++;
            $error("refund_valid high for two cycles");
        end

    a_stock_limit: assert property (@(posedge clk) disable iff (!rst) !over_limit)
        else begin
            fail_count++;
            $error("a slot holds more than the stock limit");
        end

    a_one_sale: assert property (@(posedge clk) disable iff (!rst) sold_count <= 1)
        else begin
            fail_count++;
            $error("more than one slot reports sold");
        end

    // ids 5 to 7 do not exist
    a_item_range: assert property (@(posedge clk) disable iff (!rst)
        selected_item <= 3'd4)
        else begin
            fail_count++;
            $error("selected_item out of range");
        end

endmodule

bind vending_core vend_properties i_props (
    .clk           (clk),
    .rst           (rst),
    .refund_valid  (refund_valid),
    .selected_item (selected_item),
    .report        (report)
);

// ==== verification/vending_tb.sv ====
`timescale 1ns/1ns
`include "vend_macros.svh"

module vending_tb;
    import vend_pkg::*;

    typedef enum int {
        p_idle, p_up, p_down, p_select, p_coin, p_buy, p_return, p_restock, p_admin
    } press_e;

    localparam int n_walk     = 40;
    localparam int n_coin     = 60;
    localparam int n_sat      = 26;
    localparam int n_sel_buy  = 120;
    localparam int n_fill     = 10;
    localparam int n_restock  = 80;
    localparam int n_refund   = 30;
    localparam int n_mix      = 300;
    // a refund round takes up to five cycles
    localparam int max_steps  = n_walk + n_coin + n_sat + n_sel_buy + n_fill + n_restock
                                + 5 * n_refund + n_mix + 64;
    localparam int timeout_ns = (max_steps + 2 + 100) * 4;

    logic                   clk;
    logic                   rst;
    logic [`VEND_BTN_W-1:0] button_sw_oneshot;
    logic                   admin_mode;
    logic                   admin_oneshot;
    credit_t                credit;
    slot_idx_t              cursor;
    item_t                  selected_item;
    stock_t                 shown_stock;
    status_e                status;
    credit_t                refund;
    logic                   refund_valid;

    int      seed = 42900;
    string   cur_test;
    int      err_count;
    int      errs_at_start;
    int      checks;
    int      tests_run;
    int      tests_ok;

    // reference model state
    int      m_credit;
    int      m_cursor;
    int      m_sel;
    int      m_stock [`VEND_SLOTS];
    status_e m_status;
    int      m_refund;
    logic    m_refund_valid;
    int      price [`VEND_SLOTS] = '{`VEND_PRICE_0, `VEND_PRICE_1, `VEND_PRICE_2,
                                     `VEND_PRICE_3};
    press_e  restock_kinds [5] = '{p_idle, p_up, p_down, p_restock, p_admin};

    vend_clock i_clock (
        .clk (clk),
        .rst (rst)
    );

    vending_core i_dut (
        .clk               (clk),
        .rst               (rst),
        .button_sw_oneshot (button_sw_oneshot),
        .admin_mode        (admin_mode),
        .admin_oneshot     (admin_oneshot),
        .credit            (credit),
        .cursor            (cursor),
        .selected_item     (selected_item),
        .shown_stock       (shown_stock),
        .status            (status),
        .refund            (refund),
        .refund_valid      (refund_valid)
    );

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            err_count++;
            $display("error %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model for one button cycle
    ////////////////////////////////////////////////////////////////////////////
    task automatic model_step(input logic [`VEND_BTN_W-1:0] btn, input logic aone);
        logic [2:0] coins;
        int         slot;
        logic       was_valid;
        coins = btn[`VEND_BTN_COIN_LO +: 3];
        was_valid = m_refund_valid;
        m_refund_valid = 1'b0;
        if (btn[`VEND_BTN_UP] || btn[`VEND_BTN_DOWN]) begin
            // up heads toward position 0
            if (btn[`VEND_BTN_UP]) begin
                if (m_cursor > 0)
                    m_cursor--;
            end else if (m_cursor < `VEND_SLOTS - 1) begin
                m_cursor++;
            end
            m_status = st_none;
        end else if (btn[`VEND_BTN_SELECT]) begin
            if (m_sel == m_cursor + 1)
                m_sel = 0;
            else if (m_stock[m_cursor] > 0)
                m_sel = m_cursor + 1;
            m_status = st_none;
        end else if (coins != 3'b000) begin
            m_credit += coins[2] ? `VEND_COIN_SMALL : (coins[1] ? `VEND_COIN_MID
                                                                : `VEND_COIN_LARGE);
            if (m_credit > 255)
                m_credit = 255;
            m_status = st_none;
        end else if (btn[`VEND_BTN_BUY]) begin
            if (m_sel != 0) begin
                slot = m_sel - 1;
                if (m_stock[slot] > 0 && m_credit >= price[slot]) begin
                    m_credit -= price[slot];
                    m_stock[slot]--;
                    m_status = st_sold;
                end else begin
                    m_status = st_short_credit;
                end
                m_sel = 0;
            end
        end else if (btn[`VEND_BTN_RETURN]) begin
            // the valid pulse never lasts two cycles
            m_refund       = m_credit;
            m_refund_valid = !was_valid;
            m_credit       = 0;
            m_status       = st_none;
        end else if (btn[`VEND_BTN_RESTOCK]) begin
            if (admin_mode) begin
                if (m_stock[m_cursor] < `VEND_STOCK_LIMIT)
                    m_stock[m_cursor]++;
                m_status = st_none;
            end
        end else if (aone) begin
            m_status = st_admin;
        end
    endtask

    task automatic check_outputs();
        compare("credit", m_credit, credit);
        compare("cursor", m_cursor, cursor);
        compare("selected_item", m_sel, selected_item);
        compare("shown_stock", m_stock[m_cursor], shown_stock);
        compare("status", int'(m_status), int'(status));
        compare("refund", m_refund, refund);
        compare("refund_valid", m_refund_valid, refund_valid);
    endtask

    // called just after a rising edge and checks one cycle later
    task automatic step(input logic [`VEND_BTN_W-1:0] btn, input logic aone);
        button_sw_oneshot = btn;
        admin_oneshot     = aone;
        model_step(btn, aone);
        @(posedge clk);
        #1;
        check_outputs();
        button_sw_oneshot = '0;
        admin_oneshot     = 1'b0;
    endtask

    task automatic press(input press_e kind);
        logic [`VEND_BTN_W-1:0] btn;
        logic                   aone;
        btn  = '0;
        aone = 1'b0;
        case (kind)
            p_up:      btn[`VEND_BTN_UP] = 1'b1;
            p_down:    btn[`VEND_BTN_DOWN] = 1'b1;
            p_select:  btn[`VEND_BTN_SELECT] = 1'b1;
            // any nonzero mix of the coin bits
            p_coin:    btn[`VEND_BTN_COIN_LO +: 3] = 3'(rand_below(7) + 1);
            p_buy:     btn[`VEND_BTN_BUY] = 1'b1;
            p_return:  btn[`VEND_BTN_RETURN] = 1'b1;
            p_restock: btn[`VEND_BTN_RESTOCK] = 1'b1;
            p_admin:   aone = 1'b1;
            default:   ;
        endcase
        step(btn, aone);
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        errs_at_start = err_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_count == errs_at_start) begin
            tests_ok++;
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d mismatches", cur_test, err_count - errs_at_start);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        #(timeout_ns);
        $display("timeout: the run did not finish within %0d ns", timeout_ns);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        button_sw_oneshot = '0;
        admin_mode        = 1'b0;
        admin_oneshot     = 1'b0;
        err_count         = 0;
        checks            = 0;
        tests_run         = 0;
        tests_ok          = 0;
        m_credit          = 0;
        m_cursor          = 0;
        m_sel             = 0;
        m_stock           = '{`VEND_INIT_STOCK_0, `VEND_INIT_STOCK_1, `VEND_INIT_STOCK_2,
                              `VEND_INIT_STOCK_3};
        m_status          = st_none;
        m_refund          = 0;
        m_refund_valid    = 1'b0;

        wait (rst === 1'b1);
        begin_test("reset_values");
        check_outputs();
        compare("shown_stock at slot 0", 9, shown_stock);
        end_test();

        begin_test("cursor_walk");
        repeat (n_walk) press(press_e'(rand_below(3)));
        end_test();

        begin_test("coin_credit");
        repeat (n_coin) press(rand_below(4) == 0 ? p_idle : p_coin);
        // large coins until the credit sits at full scale
        repeat (n_sat) step(`VEND_BTN_W'(1) << `VEND_BTN_COIN_LO, 1'b0);
        compare("credit saturated", 255, credit);
        end_test();

        begin_test("select_buy");
        press(p_return);
        while (m_cursor < 2) press(p_down);
        while (m_cursor > 2) press(p_up);
        // slot 2 starts empty
        press(p_select);
        compare("select on empty slot", 0, selected_item);
        while (m_cursor > 0) press(p_up);
        press(p_select);
        press(p_buy);
        compare("buy without credit", int'(st_short_credit), int'(status));
        step(`VEND_BTN_W'(1) << `VEND_BTN_COIN_LO, 1'b0);
        press(p_select);
        press(p_buy);
        compare("buy with exact credit", int'(st_sold), int'(status));
        repeat (n_sel_buy) press(press_e'(rand_below(7)));
        end_test();

        begin_test("restock_admin");
        press(p_restock);
        admin_mode = 1'b1;
        // fill the slot under the cursor past the limit
        repeat (n_fill) press(p_restock);
        compare("stock held at limit", `VEND_STOCK_LIMIT, shown_stock);
        repeat (n_restock) begin
            admin_mode = rand_below(2);
            press(restock_kinds[rand_below(5)]);
        end
        admin_mode = 1'b0;
        press(p_admin);
        end_test();

        begin_test("refund");
        repeat (n_refund) begin
            repeat (rand_below(4)) press(p_coin);
            press(p_return);
            press(p_idle);
        end
        end_test();

        begin_test("random_mix");
        repeat (n_mix) begin
            if (rand_below(8) == 0)
                admin_mode = ~admin_mode;
            press(press_e'(rand_below(9)));
        end
        end_test();

        if (i_dut.i_props.fail_count != 0) begin
            $display("concurrent assertions failed %0d times", i_dut.i_props.fail_count);
            err_count++;
        end
        $display("tests %0d, ok %0d, with mismatches %0d, checks %0d, errors %0d",
                 tests_run, tests_ok, tests_run - tests_ok, checks, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/vend_pkg.sv
rtl/panel_decoder.sv
rtl/product_slot.sv
rtl/sale_ledger.sv
rtl/vending_core.sv
verification/vend_clock.sv
verification/vend_properties.sv
verification/vending_tb.sv

// ==== Bender.yml ====
package:
  name: vending_core

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vend_pkg.sv
      - rtl/panel_decoder.sv
      - rtl/product_slot.sv
      - rtl/sale_ledger.sv
      - rtl/vending_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/vend_clock.sv
      - verification/vend_properties.sv
      - verification/vending_tb.sv
